/* Makefile */
# Verilator build and run for the bounded random number source

VERILATOR  ?= verilator
FILELIST   ?= list.f
TB_TOP     ?= rng_tb
RTL_TOP    ?= bounded_rng_top
BUILD_DIR  ?= obj_dir
PASS_MSG   ?= ** PASS **
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/$(TB_TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o $(TB_TOP)

# pass only if the simulation prints the pass message
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* hw/bounded_rng_top.sv */
`timescale 1ns/1ps
`default_nettype none

// bounded random number source
// generation, modulo and delivery chained by valid/ready links
module bounded_rng_top (
        input  wire logic                  in_clock,
        input  wire logic                  in_reset,
        input  wire lfsr_pkg::lfsr_word_t  seed,
        input  wire logic                  gen_enable,
        input  wire range_pkg::bound_t     range_min,
        input  wire range_pkg::bound_t     range_max,
        output logic                       out_req,
        input  wire logic                  out_ack,
        output range_pkg::bound_t          out_value,
        output logic                       out_range_error
);

        // generation to modulo
        logic                  gen_valid;
        logic                  gen_ready;
        lfsr_pkg::lfsr_word_t  gen_raw;
        range_pkg::bound_t     gen_min;
        range_pkg::span_t      gen_span;

        // modulo to delivery
        logic                  mod_valid;
        logic                  mod_ready;
        range_pkg::bound_t     mod_value;
        logic                  mod_range_error;

        lfsr_gen_stage u_gen (
                .in_clock   (in_clock),
                .in_reset   (in_reset),
                .seed       (seed),
                .gen_enable (gen_enable),
                .range_min  (range_min),
                .range_max  (range_max),
                .gen_valid  (gen_valid),
                .gen_ready  (gen_ready),
                .gen_raw    (gen_raw),
                .gen_min    (gen_min),
                .gen_span   (gen_span)
        );

        modulo_stage u_mod (
                .in_clock        (in_clock),
                .in_reset        (in_reset),
                .gen_valid       (gen_valid),
                .gen_ready       (gen_ready),
                .gen_raw         (gen_raw),
                .gen_min         (gen_min),
                .gen_span        (gen_span),
                .mod_valid       (mod_valid),
                .mod_ready       (mod_ready),
                .mod_value       (mod_value),
                .mod_range_error (mod_range_error)
        );

        delivery_stage u_dlv (
                .in_clock        (in_clock),
                .in_reset        (in_reset),
                .mod_valid       (mod_valid),
                .mod_ready       (mod_ready),
                .mod_value       (mod_value),
                .mod_range_error (mod_range_error),
                .out_req         (out_req),
                .out_ack         (out_ack),
                .out_value       (out_value),
                .out_range_error (out_range_error)
        );

endmodule

`default_nettype wire

/* hw/delivery_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// delivery stage
// holds one result and hands it out over the four-phase consumer port
module delivery_stage (
        input  wire logic               in_clock,
        input  wire logic               in_reset,
        input  wire logic               mod_valid,
        output logic                    mod_ready,
        input  wire range_pkg::bound_t  mod_value,
        input  wire logic               mod_range_error,
        output logic                    out_req,
        input  wire logic               out_ack,
        output range_pkg::bound_t       out_value,
        output logic                    out_range_error
);

        typedef enum logic [1:0] {
                empty,
                request,
                wait_release,
                done
        } dlv_state_t;

        dlv_state_t state;

        // holder is free before the first item and after a full handshake
        assign mod_ready = (state == empty) || (state == done);

        // req is high only while waiting for ack
        assign out_req = (state == request);

        always_ff @(posedge in_clock) begin
                if (in_reset) begin
                        state <= empty;
                end else begin
                        case (state)
                                empty, done: begin
                                        if (mod_valid) begin
                                                state <= request;
                                        end else begin
                                                state <= empty;
                                        end
                                end
                                request: begin
                                        // ack seen, req drops next cycle
                                        if (out_ack) begin
                                                state <= wait_release;
                                        end
                                end
                                wait_release: begin
                                        // consumer released ack
                                        if (!out_ack) begin
                                                state <= done;
                                        end
                                end
                                default: begin
                                        state <= empty;
                                end
                        endcase
                end
        end

        // result stays put from the transfer until the holder is free again
        always_ff @(posedge in_clock) begin
                if (mod_ready && mod_valid) begin
                        out_value       <= mod_value;
                        out_range_error <= mod_range_error;
                end
        end

endmodule

`default_nettype wire

/* hw/lfsr_gen_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// generation stage
// steps the lfsr once per item and captures the bounds with it
module lfsr_gen_stage (
        input  wire logic                  in_clock,
        input  wire logic                  in_reset,
        input  wire lfsr_pkg::lfsr_word_t  seed,
        input  wire logic                  gen_enable,
        input  wire range_pkg::bound_t     range_min,
        input  wire range_pkg::bound_t     range_max,
        output logic                       gen_valid,
        input  wire logic                  gen_ready,
        output lfsr_pkg::lfsr_word_t       gen_raw,
        output range_pkg::bound_t          gen_min,
        output range_pkg::span_t           gen_span
);

        lfsr_pkg::lfsr_word_t lfsr_state;
        lfsr_pkg::lfsr_word_t lfsr_next;
        logic                 feedback;
        logic                 step;

        // max - min needs one more bit than the span to keep the sign
        logic signed [range_pkg::span_width:0] range_diff;
        range_pkg::span_t                      step_span;

        // xor of the tapped bits
        assign feedback = ^(lfsr_state & lfsr_pkg::lfsr_taps);

        // shift left, feedback enters at bit 0
        assign lfsr_next = {lfsr_state[lfsr_pkg::lfsr_width-2:0], feedback};

        // step only when the slot is free or being taken this cycle
        assign step = gen_enable && (!gen_valid || gen_ready);

        // sign extend both bounds before subtracting
        assign range_diff = (range_pkg::span_width + 1)'(range_max)
                          - (range_pkg::span_width + 1)'(range_min);

        // negative difference means min > max, pass span zero
        assign step_span = range_diff[range_pkg::span_width]
                         ? '0 : range_pkg::span_t'(range_diff + 1);

        // lfsr state and slot valid
        always_ff @(posedge in_clock) begin
                if (in_reset) begin
                        // seed sampled on every reset cycle
                        lfsr_state <= (seed == '0) ? lfsr_pkg::zero_seed_value : seed;
                        gen_valid  <= 1'b0;
                end else if (step) begin
                        lfsr_state <= lfsr_next;
                        gen_valid  <= 1'b1;
                end else if (gen_ready) begin
                        // slot drained with nothing new behind it
                        gen_valid <= 1'b0;
                end
        end

        // slot payload, written only on a step
        always_ff @(posedge in_clock) begin
                if (!in_reset && step) begin
                        gen_raw  <= lfsr_next;
                        gen_min  <= range_min;
                        gen_span <= step_span;
                end
        end

endmodule

`default_nettype wire

/* hw/lfsr_pkg.sv */
`default_nettype none

// lfsr word definitions shared by the generator and its reference model
package lfsr_pkg;

        // one width only
        localparam int lfsr_width = 32;

        // lfsr state and raw word
        typedef logic [lfsr_width-1:0] lfsr_word_t;

        // feedback taps as a mask, bits 31, 21, 1 and 0
        // feedback is the xor of the masked bits, shifted in at bit 0
        localparam lfsr_word_t lfsr_taps = 32'h8020_0003;

        // an all-zero state never leaves zero
        // so a zero seed is swapped for this value
        localparam lfsr_word_t zero_seed_value = 32'h0000_0001;

endpackage

`default_nettype wire

/* hw/modulo_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// modulo stage
// restoring remainder of the unsigned raw word by the span, two bits per cycle
module modulo_stage (
        input  wire logic                  in_clock,
        input  wire logic                  in_reset,
        input  wire logic                  gen_valid,
        output logic                       gen_ready,
        input  wire lfsr_pkg::lfsr_word_t  gen_raw,
        input  wire range_pkg::bound_t     gen_min,
        input  wire range_pkg::span_t      gen_span,
        output logic                       mod_valid,
        input  wire logic                  mod_ready,
        output range_pkg::bound_t          mod_value,
        output logic                       mod_range_error
);

        typedef enum logic [1:0] {
                idle,
                iterate,
                finish,
                hold
        } mod_state_t;

        mod_state_t state;

        // raw word padded with two zero bits, 17 passes of two bits each
        logic [lfsr_pkg::lfsr_width+1:0] dividend_q;
        range_pkg::remainder_t           rem_q;
        range_pkg::remainder_t           rem_mid;
        range_pkg::remainder_t           rem_next;
        range_pkg::bound_t               min_q;
        range_pkg::span_t                span_q;
        logic [4:0]                      iter_left;

        // one restoring step: shift in a bit, subtract when it fits
        function automatic range_pkg::remainder_t rem_step(
                input range_pkg::remainder_t part,
                input logic                  din,
                input range_pkg::span_t      divisor);
                logic [range_pkg::remainder_width:0] shifted;
                shifted = {part, din};
                if (shifted >= {1'b0, divisor}) begin
                        shifted = shifted - {1'b0, divisor};
                end
                // result is below the divisor, top bit is clear
                return range_pkg::remainder_t'(shifted);
        endfunction

        // upper bit first, then the lower one
        assign rem_mid  = rem_step(rem_q, dividend_q[lfsr_pkg::lfsr_width+1], span_q);
        assign rem_next = rem_step(rem_mid, dividend_q[lfsr_pkg::lfsr_width], span_q);

        assign gen_ready = (state == idle);

        // control
        always_ff @(posedge in_clock) begin
                if (in_reset) begin
                        state     <= idle;
                        mod_valid <= 1'b0;
                end else begin
                        case (state)
                                idle: begin
                                        if (gen_valid) begin
                                                state <= iterate;
                                        end
                                end
                                iterate: begin
                                        if (iter_left == '0) begin
                                                state <= finish;
                                        end
                                end
                                finish: begin
                                        state     <= hold;
                                        mod_valid <= 1'b1;
                                end
                                hold: begin
                                        if (mod_ready) begin
                                                state     <= idle;
                                                mod_valid <= 1'b0;
                                        end
                                end
                                default: begin
                                        state <= idle;
                                end
                        endcase
                end
        end

        // datapath
        always_ff @(posedge in_clock) begin
                if (state == idle && gen_valid) begin
                        dividend_q <= {2'b00, gen_raw};
                        rem_q      <= '0;
                        min_q      <= gen_min;
                        span_q     <= gen_span;
                        // counts 16 down to 0, one pass per count
                        iter_left  <= 5'(lfsr_pkg::lfsr_width / 2);
                end
                if (state == iterate) begin
                        rem_q      <= rem_next;
                        dividend_q <= dividend_q << 2;
                        iter_left  <= iter_left - 5'd1;
                end
                if (state == finish) begin
                        // zero span is a bad range, report min
                        mod_range_error <= (span_q == '0);
                        if (span_q == '0) begin
                                mod_value <= min_q;
                        end else begin
                                // remainder <= max - min, sum stays in range
                                mod_value <= min_q + range_pkg::bound_t'(rem_q);
                        end
                end
        end

endmodule

`default_nettype wire

/* hw/range_pkg.sv */
`default_nettype none

// bound, span and remainder definitions for the range reduction
package range_pkg;

        // signed bounds and delivered values
        localparam int bound_width = 16;

        // span is max - min + 1, up to 65536, one bit wider than a bound
        localparam int span_width = bound_width + 1;

        // remainder is always below the span
        localparam int remainder_width = span_width;

        // range_min, range_max and out_value
        typedef logic signed [bound_width-1:0] bound_t;

        // unsigned span, zero marks a bad range
        typedef logic [span_width-1:0] span_t;

        // result of raw word modulo span
        typedef logic [remainder_width-1:0] remainder_t;

endpackage

`default_nettype wire

/* list.f */
hw/lfsr_pkg.sv
hw/range_pkg.sv
hw/lfsr_gen_stage.sv
hw/modulo_stage.sv
hw/delivery_stage.sv
hw/bounded_rng_top.sv
test/rng_tb.sv

/* test/rng_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the bounded random number source
module rng_tb;

        // item budget allows three leftovers per test
        localparam int item_budget    = 140 + 7 * 3;
        // margin for 40 quiet cycles per drain plus both resets
        localparam int margin_cycles  = 7 * 40 + 2 * 10 + 200;
        localparam int timeout_cycles = item_budget * 25 + margin_cycles;

        logic                 in_clock = 1'b0;
        logic                 in_reset;
        lfsr_pkg::lfsr_word_t seed;
        logic                 gen_enable;
        range_pkg::bound_t    range_min;
        range_pkg::bound_t    range_max;
        logic                 out_req;
        logic                 out_ack;
        range_pkg::bound_t    out_value;
        logic                 out_range_error;

        // reference lfsr and ack delay source
        lfsr_pkg::lfsr_word_t model_state;
        logic [31:0]          rnd_state = 32'h1fc7_51e7;

        int check_errors    = 0;
        int protocol_errors = 0;
        int items_checked   = 0;
        int test_count      = 0;
        int cycle_count     = 0;

        // monitor history from the previous negedge
        logic              prev_req;
        logic              prev_ack;
        logic              prev_error;
        range_pkg::bound_t prev_value;

        bounded_rng_top uut (
                .in_clock        (in_clock),
                .in_reset        (in_reset),
                .seed            (seed),
                .gen_enable      (gen_enable),
                .range_min       (range_min),
                .range_max       (range_max),
                .out_req         (out_req),
                .out_ack         (out_ack),
                .out_value       (out_value),
                .out_range_error (out_range_error)
        );

        always #20 in_clock = ~in_clock;

        // one fibonacci step with the xor of tapped bits entering at bit 0
        function automatic lfsr_pkg::lfsr_word_t lfsr_advance(input lfsr_pkg::lfsr_word_t s);
                logic fb;
                int   i;
                fb = 1'b0;
                for (i = 0; i < lfsr_pkg::lfsr_width; i++) begin
                        if (lfsr_pkg::lfsr_taps[i]) begin
                                fb = fb ^ s[i];
                        end
                end
                return {s[lfsr_pkg::lfsr_width-2:0], fb};
        endfunction

        // min + raw mod (max - min + 1)
        // a bad range gives min
        function automatic int expected_value(input lfsr_pkg::lfsr_word_t raw, input int lo,
                                              input int hi);
                int                   span;
                lfsr_pkg::lfsr_word_t rem;
                span = hi - lo + 1;
                if (span <= 0) begin
                        return lo;
                end
                rem = raw % lfsr_pkg::lfsr_word_t'(span);
                return lo + int'(rem);
        endfunction

        function automatic logic [31:0] galois_step(input logic [31:0] s);
                if (s[0]) begin
                        return (s >> 1) ^ 32'hb4bc_d35c;
                end
                return s >> 1;
        endfunction

        // n random bits with the first one as msb
        function automatic int random_bits(input int n);
                int v;
                int k;
                v = 0;
                for (k = 0; k < n; k++) begin
                        rnd_state = galois_step(rnd_state);
                        v = (v << 1) | int'(rnd_state[0]);
                end
                return v;
        endfunction

        // all drives land 2 ns after the rising edge
        task automatic next_cycle();
                @(posedge in_clock);
                #2;
        endtask

        task automatic apply_reset(input lfsr_pkg::lfsr_word_t seed_value);
                gen_enable = 1'b0;
                out_ack    = 1'b0;
                seed       = seed_value;
                in_reset   = 1'b1;
                repeat (10) next_cycle();
                in_reset   = 1'b0;
                model_state = (seed_value == '0) ? lfsr_pkg::zero_seed_value : seed_value;
        endtask

        // wait for req, check the item, then run the four-phase handshake
        task automatic take_item(input string name, input int lo, input int hi,
                                 input bit random_ack);
                int   got;
                int   exp;
                int   delay;
                logic got_err;
                logic exp_err;
                while (!out_req) begin
                        next_cycle();
                end
                got         = int'(out_value);
                got_err     = out_range_error;
                model_state = lfsr_advance(model_state);
                exp         = expected_value(model_state, lo, hi);
                exp_err     = (hi < lo);
                assert (got == exp) else begin
                        $display("FAIL %s: expected %0d, actual %0d", name, exp, got);
                        check_errors++;
                end
                assert (got_err == exp_err) else begin
                        $display("FAIL %s range error: expected %0b, actual %0b", name, exp_err,
                                 got_err);
                        check_errors++;
                end
                if (lo <= hi) begin
                        assert (got >= lo && got <= hi) else begin
                                $display("FAIL %s: expected %0d to %0d, actual %0d",
                                         name, lo, hi, got);
                                check_errors++;
                        end
                end
                items_checked++;
                // 0 to 7 cycles before ack
                delay = random_ack ? random_bits(3) : 0;
                repeat (delay) next_cycle();
                out_ack = 1'b1;
                do begin
                        next_cycle();
                end while (out_req);
                out_ack = 1'b0;
        endtask

        // one test takes count items then drops enable and drains the pipeline
        task automatic run_items(input string name, input int count, input int lo, input int hi,
                                 input bit random_ack);
                int errors_before;
                int extras;
                int quiet;
                errors_before = check_errors + protocol_errors;
                range_min     = range_pkg::bound_t'(lo);
                range_max     = range_pkg::bound_t'(hi);
                gen_enable    = 1'b1;
                repeat (count) take_item(name, lo, hi, random_ack);
                gen_enable = 1'b0;
                extras     = 0;
                quiet      = 0;
                // items still in flight deliver with up to one per stage
                while (quiet < 40) begin
                        next_cycle();
                        if (out_req) begin
                                take_item(name, lo, hi, random_ack);
                                extras++;
                                quiet = 0;
                        end else begin
                                quiet++;
                        end
                end
                assert (extras <= 3) else begin
                        $display("%s: %0d items after gen_enable dropped, at most 3 allowed",
                                 name, extras);
                        check_errors++;
                end
                test_count++;
                $display("test %0d %s: %0d items, %0d after drop, %0d errors", test_count, name,
                         count + extras, extras, check_errors + protocol_errors - errors_before);
        endtask

        // consumer port protocol sampled mid-cycle where all signals are settled
        always @(negedge in_clock) begin
                if (in_reset) begin
                        prev_req = 1'b0;
                        prev_ack = 1'b0;
                end else begin
                        if (prev_req && out_req) begin
                                assert (out_value == prev_value && out_range_error == prev_error)
                                else begin
                                        $display("out_value changed while out_req was high");
                                        protocol_errors++;
                                end
                        end
                        if (out_req && !prev_req) begin
                                assert (!prev_ack) else begin
                                        $display("out_req rose while out_ack was still high");
                                        protocol_errors++;
                                end
                        end
                        if (prev_req && !out_req) begin
                                assert (prev_ack) else begin
                                        $display("out_req dropped before out_ack was raised");
                                        protocol_errors++;
                                end
                        end
                        prev_req   = out_req;
                        prev_ack   = out_ack;
                        prev_value = out_value;
                        prev_error = out_range_error;
                end
        end

        // watchdog
        always @(posedge in_clock) begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= timeout_cycles) begin
                        $display("timeout after %0d cycles, the consumer handshake stalled",
                                 cycle_count);
                        $display("** FAIL **");
                        $finish;
                end
        end

        initial begin
                in_reset   = 1'b1;
                seed       = '0;
                gen_enable = 1'b0;
                range_min  = '0;
                range_max  = '0;
                out_ack    = 1'b0;

                apply_reset(32'h1234_5678);
                run_items("seed_start", 20, 0, 9, 1'b0);
                run_items("random_ack", 40, -1000, 1000, 1'b1);
                run_items("bound_change", 10, 100, 163, 1'b1);
                // zero seed is swapped inside the generator
                apply_reset('0);
                run_items("zero_seed", 20, 0, 255, 1'b1);
                run_items("inverted_range", 10, 50, -50, 1'b1);
                run_items("single_value", 10, 5, 5, 1'b1);
                run_items("full_range", 30, -32768, 32767, 1'b1);

                $display("tests %0d, items %0d, value errors %0d, protocol errors %0d", test_count,
                         items_checked, check_errors, protocol_errors);
                if (check_errors == 0 && protocol_errors == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

endmodule

`default_nettype wire
